//--- rtl/nd_proc_pkg.sv
// ==============================
// ND120 processor shared types
// Microword field positions, IDB source
// and command codes, bus word types
// ==============================
`default_nettype none

package nd_proc_pkg;

  typedef logic [63:0] csbits_t;        // Full microinstruction word
  typedef logic [15:0] idb_word_t;      // IDB, gate-array bus and RF word

  localparam int unsigned bank_w = 2;   // RF bank select width
  localparam int unsigned op_w   = 4;   // A and B operand width

  // RF address as laid out on the RAM pins, high to low
  typedef struct packed {
    logic [bank_w-1:0] bank;            // Bank from the gate array
    logic [op_w-1:0]   lba;             // B operand
    logic [op_w-1:0]   laa;             // A operand
  } rf_addr_t;

  localparam int unsigned csidbs_lsb = 37;  // IDB source field
  localparam int unsigned csidbs_w   = 5;
  localparam int unsigned cscomm_lsb = 32;  // Command field
  localparam int unsigned cscomm_w   = 5;
  localparam int unsigned lba_lsb    = 16;  // B operand field
  localparam int unsigned laa_lsb    = 20;  // A operand field

  localparam logic [csidbs_w-1:0] idbs_reg = 5'd5;   // Source REG
  localparam logic [cscomm_w-1:0] cmd_wrf  = 5'd14;  // Command WRF

  localparam int unsigned rf_depth_default = 1024;  // Bit 10 grounded on the sheet

endpackage

`default_nettype wire

//--- rtl/rf_port_if.sv
// ==============================
// Register-file access port
// Address, select and write strobe from
// the decoder, data from router and RAM
// ==============================
`default_nettype none

interface rf_port_if #(
  parameter type word_t = nd_proc_pkg::idb_word_t  // Payload carried on the port
) ();
  import nd_proc_pkg::*;

  rf_addr_t addr;    // Bank, B and A operand
  logic     cs_n;    // Chip select, ERF_n on the sheet
  logic     we_n;    // Gated write, TWRF_n on the sheet
  word_t    wdata;   // Merged write data
  word_t    rdata;   // Zero unless reading

  modport decode (
    output addr,
    output cs_n,
    output we_n
  );

  modport router (
    input  rdata,
    output wdata
  );

  modport ram (
    input  addr,
    input  cs_n,
    input  we_n,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- rtl/csword_decode.sv
// ==============================
// Microword decode for the RF
// Forms read flag, chip select, gated
// write strobe and the RF address
// ==============================
`default_nettype none

module csword_decode (
  input  wire logic                 rst_n,    // Async reset, active low
  input  wire nd_proc_pkg::csbits_t csbits,   // Microinstruction word
  input  wire logic [1:0]           rf_bank,  // Bank number
  input  wire logic                 wrfstb,   // Write RF strobe
  input  wire logic                 term_n,   // Bus cycle terminate
  output logic                      rrf_n,    // Read RF flag
  rf_port_if.decode                 rf        // RF access port
);
  import nd_proc_pkg::*;

  logic [csidbs_w-1:0] csidbs;   // IDB source
  logic [cscomm_w-1:0] cscomm;   // Command
  logic [op_w-1:0]     laa;      // A operand
  logic [op_w-1:0]     lba;      // B operand
  logic                src_reg;  // Source is REG
  logic                cmd_wr;   // Command is WRF
  logic                wr_go;    // All write terms true

  assign csidbs  = csbits[csidbs_lsb +: csidbs_w];
  assign cscomm  = csbits[cscomm_lsb +: cscomm_w];
  assign laa     = csbits[laa_lsb +: op_w];
  assign lba     = csbits[lba_lsb +: op_w];

  assign src_reg = (csidbs == idbs_reg);
  assign cmd_wr  = (cscomm == cmd_wrf);

  // Strobe qualified by terminate, as the NAND on the sheet
  assign wr_go   = cmd_wr & wrfstb & term_n;

  always_comb begin
    rrf_n       = 1'b1;  // Inactive while in reset
    rf.cs_n     = 1'b1;
    rf.we_n     = 1'b1;
    rf.addr     = '0;
    if (rst_n) begin
      rrf_n         = ~src_reg;           // Low on a REG source
      rf.cs_n       = ~(src_reg | cmd_wr); // Select on read or write
      rf.we_n       = ~wr_go;
      rf.addr.bank  = rf_bank;
      rf.addr.lba   = lba;
      rf.addr.laa   = laa;
    end
  end

endmodule

`default_nettype wire

//--- rtl/regfile_ram.sv
// ==============================
// Register-file RAM
// Synchronous write, combinational read,
// zero on the bus when not reading
// ==============================
`default_nettype none

module regfile_ram #(
  parameter int unsigned depth  = nd_proc_pkg::rf_depth_default,  // Number of words
  parameter type         word_t = nd_proc_pkg::idb_word_t         // Stored payload
) (
  input  wire logic sysclk,  // System clock
  rf_port_if.ram    rf       // Access from decoder and router
);

  word_t mem [depth];  // Two byte-wide chips as one array

  logic rd_en;  // Selected and not writing
  logic wr_en;  // Selected and writing

  assign wr_en = ~rf.cs_n & ~rf.we_n;
  assign rd_en = ~rf.cs_n & rf.we_n;

  // Write lands on the edge with the strobe active
  always_ff @(posedge sysclk) begin
    if (wr_en) begin
      mem[rf.addr] <= rf.wdata;
    end
  end

  // Outputs float on the real part, modelled as zero for the OR merge
  always_comb begin
    if (rd_en) begin
      rf.rdata = mem[rf.addr];  // Read through in the same cycle
    end else begin
      rf.rdata = '0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/idb_router.sv
// ==============================
// IDB router
// Byte transceivers to the gate-array bus
// and OR merge of IDB and RF data
// ==============================
`default_nettype none

module idb_router (
  input  wire logic                   bedo_n,    // Direction, low drives A side
  input  wire logic                   estof_n,   // Transceiver enable, active low
  input  wire nd_proc_pkg::idb_word_t idb_in,    // IDB from outside
  input  wire nd_proc_pkg::idb_word_t fidb_in,   // Gate-array bus into B side
  output nd_proc_pkg::idb_word_t      idb_out,   // Merged IDB out
  output nd_proc_pkg::idb_word_t      fidb_out,  // B side toward gate array
  rf_port_if.router                   rf         // RF data path
);
  import nd_proc_pkg::*;

  idb_word_t a_in;   // A-side input
  idb_word_t a_out;  // A-side output
  idb_word_t b_out;  // B-side output
  logic      b2a;    // Driving toward the IDB
  logic      a2b;    // Driving toward the gate array

  // One 16-bit path stands for both byte chips
  assign b2a = ~estof_n & ~bedo_n;
  assign a2b = ~estof_n & bedo_n;

  // Undriven bus lines read as zero
  assign a_in  = idb_in | rf.rdata;
  assign a_out = b2a ? fidb_in : '0;
  assign b_out = a2b ? a_in : '0;

  assign fidb_out = b_out;
  assign idb_out  = rf.rdata | a_out;  // RF read or gate-array data
  assign rf.wdata = idb_in | a_out;    // Write source, never RF itself

endmodule

`default_nettype wire

//--- rtl/proc_regfile_top.sv
// ==============================
// ND120 register-file subsystem
// Microword decode, RF RAM and IDB
// router with plain top-level ports
// ==============================
`default_nettype none

module proc_regfile_top #(
  parameter int unsigned rf_depth = nd_proc_pkg::rf_depth_default  // RF words
) (
  input  wire logic                   sysclk,    // System clock
  input  wire logic                   rst_n,     // Async reset, active low
  input  wire nd_proc_pkg::csbits_t   csbits,    // Microinstruction word
  input  wire logic [1:0]             rf_bank,   // RF bank from gate array
  input  wire logic                   wrfstb,    // Write RF strobe
  input  wire logic                   term_n,    // Terminate bus cycle
  input  wire logic                   bedo_n,    // Transceiver direction
  input  wire logic                   estof_n,   // Transceiver enable
  input  wire nd_proc_pkg::idb_word_t idb_in,    // IDB in
  input  wire nd_proc_pkg::idb_word_t fidb_in,   // Gate-array bus in
  output nd_proc_pkg::idb_word_t      idb_out,   // IDB out
  output nd_proc_pkg::idb_word_t      fidb_out,  // Gate-array bus out
  output logic                        rrf_n      // Read RF flag
);
  import nd_proc_pkg::*;

  // Single RF access shared by all three blocks
  rf_port_if #(
    .word_t (idb_word_t)
  ) rf_bus ();

  csword_decode u_decode (
    .rst_n   (rst_n),
    .csbits  (csbits),
    .rf_bank (rf_bank),
    .wrfstb  (wrfstb),
    .term_n  (term_n),
    .rrf_n   (rrf_n),
    .rf      (rf_bus.decode)
  );

  regfile_ram #(
    .depth  (rf_depth),
    .word_t (idb_word_t)
  ) u_ram (
    .sysclk (sysclk),
    .rf     (rf_bus.ram)
  );

  idb_router u_router (
    .bedo_n   (bedo_n),
    .estof_n  (estof_n),
    .idb_in   (idb_in),
    .fidb_in  (fidb_in),
    .idb_out  (idb_out),
    .fidb_out (fidb_out),
    .rf       (rf_bus.router)
  );

endmodule

`default_nettype wire

//--- dv/tb_proc_regfile.sv
// ==============================
// Testbench for the RF subsystem
// Reads per-cycle vectors, drives the DUT
// and checks IDB, gate-array bus and rrf_n
// ==============================
`default_nettype none

module tb_proc_regfile;
  import nd_proc_pkg::*;

  localparam int    clk_half     = 10;   // Period 20
  localparam int    reset_cycles = 16;
  localparam int    drive_delay  = 2;    // Inputs change after the edge
  localparam int    sample_delay = 16;   // Two units before the next edge
  localparam int    max_cycles   = 200;  // Vector loop limit
  localparam int    n_fields     = 12;   // Columns per vector
  localparam string stim_path    = "dv/regfile_stimulus.txt";

  logic      sysclk;    // Free-running clock
  logic      rst_n;     // Async reset, active low
  csbits_t   csbits;    // Microword to DUT
  logic [1:0] rf_bank;  // Bank number
  logic      wrfstb;    // Write RF strobe
  logic      term_n;    // Bus terminate
  logic      bedo_n;    // Transceiver direction
  logic      estof_n;   // Transceiver enable
  idb_word_t idb_in;    // IDB into DUT
  idb_word_t fidb_in;   // Gate-array bus into DUT
  idb_word_t idb_out;   // IDB from DUT
  idb_word_t fidb_out;  // Gate-array bus from DUT
  logic      rrf_n;     // Read RF flag from DUT

  // Fields of the current vector
  logic        v_rst_n;
  logic [63:0] v_csbits;
  logic [1:0]  v_bank;
  logic        v_wrfstb;
  logic        v_term_n;
  logic        v_bedo_n;
  logic        v_estof_n;
  logic [15:0] v_idb_in;
  logic [15:0] v_fidb_in;
  logic [15:0] v_exp_idb;   // Expected idb_out
  logic [15:0] v_exp_fidb;  // Expected fidb_out
  logic        v_exp_rrf;   // Expected rrf_n

  proc_regfile_top #(
    .rf_depth (rf_depth_default)
  ) u_dut (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .csbits   (csbits),
    .rf_bank  (rf_bank),
    .wrfstb   (wrfstb),
    .term_n   (term_n),
    .bedo_n   (bedo_n),
    .estof_n  (estof_n),
    .idb_in   (idb_in),
    .fidb_in  (fidb_in),
    .idb_out  (idb_out),
    .fidb_out (fidb_out),
    .rrf_n    (rrf_n)
  );

  initial begin
    sysclk = 1'b0;
    forever #(clk_half) sysclk = ~sysclk;
  end

  // Compare one output against its expected value
  task automatic check_value(
    input string       name,
    input logic [15:0] actual,
    input logic [15:0] expected
  );
    if (actual !== expected) begin
      $display("ERR time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      $display("Regression failed");
      $fatal(1, "Output mismatch on %s", name);
    end
  endtask

  // Failure that is not a wrong value
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic drive_idle();
    csbits  = '0;     // Source and command both zero
    rf_bank = 2'd0;
    wrfstb  = 1'b0;
    term_n  = 1'b1;
    bedo_n  = 1'b1;
    estof_n = 1'b1;   // Transceiver off
    idb_in  = '0;
    fidb_in = '0;
  endtask

  task automatic apply_vector();
    rst_n   = v_rst_n;
    csbits  = v_csbits;
    rf_bank = v_bank;
    wrfstb  = v_wrfstb;
    term_n  = v_term_n;
    bedo_n  = v_bedo_n;
    estof_n = v_estof_n;
    idb_in  = v_idb_in;
    fidb_in = v_fidb_in;
  endtask

  task automatic check_vector();
    check_value("idb_out", idb_out, v_exp_idb);
    check_value("fidb_out", fidb_out, v_exp_fidb);
    check_value("rrf_n", {15'd0, rrf_n}, {15'd0, v_exp_rrf});
  endtask

  // Blank lines and # lines carry no vector
  function automatic bit is_comment(input string line);
    if (line.len() == 0) begin
      return 1'b1;
    end
    return (line[0] == "#") || (line[0] == "\n") || (line[0] == "\r");
  endfunction

  initial begin : main
    int    fd;        // Stimulus file handle
    int    code;      // $fgets result
    int    fields;    // Fields parsed from a line
    int    cycle;     // Vector cycles run so far
    int    n_vec;     // Vectors checked
    string line;

    cycle = 0;
    n_vec = 0;
    rst_n = 1'b0;
    drive_idle();
    csbits[csidbs_lsb +: csidbs_w] = idbs_reg;  // Register read pending in reset

    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      stop_run("Could not open the stimulus file dv/regfile_stimulus.txt");
    end

    // Outputs stay quiet through reset despite the pending read
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge sysclk);
      if (i < reset_cycles - 1) begin
        #(drive_delay + sample_delay);
        check_value("rrf_n", {15'd0, rrf_n}, 16'd1);
        check_value("idb_out", idb_out, 16'd0);
        check_value("fidb_out", fidb_out, 16'd0);
      end
    end

    // One vector per cycle with rst_n taken from the file
    while ($feof(fd) == 0) begin
      if (cycle >= max_cycles) begin
        $fclose(fd);
        stop_run("Timeout, the vector loop ran past its cycle limit");
      end
      code = $fgets(line, fd);
      if (code > 0 && !is_comment(line)) begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                         v_rst_n, v_csbits, v_bank, v_wrfstb, v_term_n, v_bedo_n,
                         v_estof_n, v_idb_in, v_fidb_in, v_exp_idb, v_exp_fidb,
                         v_exp_rrf);
        if (fields != n_fields) begin
          $fclose(fd);
          stop_run("A stimulus line does not hold twelve hex fields");
        end
        #(drive_delay);
        apply_vector();
        #(sample_delay);
        check_vector();  // Just before the write edge
        @(posedge sysclk);
        cycle++;
        n_vec++;
      end
    end
    $fclose(fd);

    if (n_vec == 0) begin
      stop_run("The stimulus file holds no vectors");
    end else begin
      $display("%0d vectors checked", n_vec);
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- dv/regfile_stimulus.txt
# Columns, hex: rst_n csbits rf_bank wrfstb term_n bedo_n estof_n idb_in fidb_in
# then expected idb_out fidb_out rrf_n; one vector per clock cycle
# Writes and reads are held off while rst_n is low
1 0000000e00320000 0 1 1 1 1 0000 0000 0000 0000 1
0 0000000e00320000 0 1 1 1 1 dead 0000 0000 0000 1
0 000000a000320000 0 0 1 1 1 0000 0000 0000 0000 1
0 0000000e00320000 0 1 1 1 1 beef 0000 0000 0000 1
1 000000a000320000 0 0 1 1 1 0000 0000 0000 0000 0
# IDB write then register read, transceiver off
1 0000000e00560000 1 1 1 1 1 1234 0000 0000 0000 1
1 000000a000560000 1 0 1 1 1 0000 0000 1234 0000 0
1 0000000000000000 0 0 1 1 1 0000 0000 0000 0000 1
1 000000a000560000 1 0 1 1 1 ff00 0000 1234 0000 0
# Gate-array data toward the IDB
1 0000000000000000 0 0 1 0 0 0f0f a5c3 a5c3 0000 1
1 000000a000560000 1 0 1 0 0 0000 0c00 1e34 0000 0
1 0000000000000000 0 0 1 0 1 ffff ffff 0000 0000 1
# IDB toward the gate array
1 0000000000000000 0 0 1 1 0 3c3c ffff 0000 3c3c 1
1 000000a000560000 1 0 1 1 0 4001 ffff 1234 5235 0
# Writes with the transceiver on
1 0000000e00a90000 2 1 1 0 0 00f0 1200 1200 0000 1
1 000000a000a90000 2 0 1 1 1 0000 0000 12f0 0000 0
1 0000000e00320000 0 1 1 1 0 8421 ffff 0000 8421 1
1 000000a000320000 0 0 1 1 1 0000 0000 8421 0000 0
# Banks with the same operands, then blocked writes
1 0000000e00a90000 3 1 1 1 1 7777 0000 0000 0000 1
1 000000a000a90000 3 0 1 1 1 0000 0000 7777 0000 0
1 000000a000a90000 2 0 1 1 1 0000 0000 12f0 0000 0
1 0000000e00a90000 0 1 1 1 1 1111 0000 0000 0000 1
1 0000000e00a90000 1 1 1 1 1 2222 0000 0000 0000 1
1 000000a000a90000 0 0 1 1 1 0000 0000 1111 0000 0
1 000000a000a90000 1 0 1 1 1 0000 0000 2222 0000 0
1 000000a000a90000 3 0 1 1 1 0000 0000 7777 0000 0
1 0000000e00a90000 3 1 0 1 1 0bad 0000 7777 0000 1
1 0000000e00a90000 3 0 1 1 1 0bad 0000 7777 0000 1
1 000000a000a90000 3 0 1 1 1 0000 0000 7777 0000 0
1 0000000d00a90000 3 1 1 1 1 0bad 0000 0000 0000 1
1 000000a000a90000 3 0 1 1 1 0000 0000 7777 0000 0
# Swapped operand fields address another word
1 0000000e00230000 0 1 1 1 1 0055 0000 0000 0000 1
1 000000a000320000 0 0 1 1 1 0000 0000 8421 0000 0
1 000000a000230000 0 0 1 1 1 0000 0000 0055 0000 0
1 0000000000000000 0 0 1 1 1 0000 0000 0000 0000 1

//--- flist.f
rtl/nd_proc_pkg.sv
rtl/rf_port_if.sv
rtl/csword_decode.sv
rtl/regfile_ram.sv
rtl/idb_router.sv
rtl/proc_regfile_top.sv
dv/tb_proc_regfile.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the register-file testbench with Verilator.
# The exit status is the simulator's own, nonzero on a failed run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module tb_proc_regfile \
  -f flist.f \
  -o sim_tb_proc_regfile

# Run from the project root so the stimulus path resolves
./obj_dir/sim_tb_proc_regfile

echo "Simulation finished"
